// ==== rtl/buf_params.svh ====
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// --------------------
// Word stream
// --------------------

// Width of one data word on the write and read side
`define BUF_WORD_WIDTH 16

// Word FIFO entries, shared by all buffered messages
`define BUF_WORD_DEPTH 8

// --------------------
// Message lengths
// --------------------

// Length FIFO entries, one per finished message
`define BUF_LEN_DEPTH 4

// 8 bits hold lengths 1 to 255
`define BUF_LEN_WIDTH 8

`endif

// ==== rtl/buf_types_pkg.sv ====
`include "buf_params.svh"

package buf_types_pkg;

    // --------------------
    // Word FIFO payload
    // --------------------

    // One stored word
    // Last marks the final word of a message
    typedef struct packed {
        logic [`BUF_WORD_WIDTH-1:0] data;
        logic                       last;
    } word_t;

    // --------------------
    // Length FIFO payload
    // --------------------

    // Number of words in one finished message
    // Zero never appears, a message has at least its last word
    typedef logic [`BUF_LEN_WIDTH-1:0] msg_len_t;

    // Longest message the buffer can describe
    localparam msg_len_t MSG_LEN_MAX = '1;

endpackage : buf_types_pkg

// ==== rtl/fifo_pkg.sv ====
package fifo_pkg;

    // --------------------
    // FIFO control state
    // --------------------

    // Fill level as seen by the control FSM
    // EMPTY    no entries, reads are blocked
    // PARTIAL  at least one entry and at least one free slot
    // FULL     all slots taken, writes are blocked
    typedef enum logic [1:0] {
        EMPTY   = 2'b00,
        PARTIAL = 2'b01,
        FULL    = 2'b10
    } ctrl_state_e;

    // Encoding 2'b11 is unused
    // The FSM falls back to EMPTY if it ever sees it

endpackage : fifo_pkg

// ==== rtl/fifo_ctrl_fsm.sv ====
module fifo_ctrl_fsm #(
    parameter int  DEPTH   = 4,
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic               clk,
    input  logic               reset,

    // Write side
    input  logic               wr,
    output logic               wr_safe,
    output logic [PTR_WID-1:0] wr_ptr,
    output logic               full,
    output logic               oflow,

    // Read side
    input  logic               rd,
    output logic [PTR_WID-1:0] rd_ptr,
    output logic               empty,
    output logic               uflow
);
    import fifo_pkg::*;

    // --------------------
    // Parameters
    // --------------------

    // Count runs 0 to DEPTH inclusive
    localparam int                 CNT_WID  = $clog2(DEPTH + 1);
    localparam logic [CNT_WID-1:0] CNT_MAX  = CNT_WID'(DEPTH);
    localparam logic [PTR_WID-1:0] PTR_LAST = PTR_WID'(DEPTH - 1);

    // --------------------
    // Signals
    // --------------------

    ctrl_state_e        state;
    ctrl_state_e        state_next;
    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] count_next;
    logic               rd_safe;

    // Levels come straight from the registered state
    assign full  = (state == FULL);
    assign empty = (state == EMPTY);

    // Protection: drop writes when full, ignore reads when empty
    assign wr_safe = wr && !full;
    assign rd_safe = rd && !empty;

    // --------------------
    // Fill count
    // --------------------

    // Simultaneous read and write leaves the count alone
    always_comb begin
        case ({wr_safe, rd_safe})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // --------------------
    // State transitions
    // --------------------

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                // DEPTH of 1 goes straight to FULL
                if (wr_safe) begin
                    state_next = (count_next == CNT_MAX) ? FULL : PARTIAL;
                end
            end
            PARTIAL: begin
                if (count_next == CNT_MAX) begin
                    state_next = FULL;
                end else if (count_next == '0) begin
                    state_next = EMPTY;
                end
            end
            FULL: begin
                // Only a read can leave FULL
                if (rd_safe) begin
                    state_next = (count_next == '0) ? EMPTY : PARTIAL;
                end
            end
            default: begin
                state_next = EMPTY;
            end
        endcase
    end

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= EMPTY;
            count  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            oflow  <= 1'b0;
            uflow  <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            // Pointers wrap at DEPTH, which need not be a power of two
            if (wr_safe) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_safe) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // One-cycle flags for blocked operations
            oflow <= wr && full;
            uflow <= rd && empty;
        end
    end

    // --------------------
    // Assertions
    // --------------------

    // Count can never pass the number of slots
    a_count_max: assert property (
        @(posedge clk) disable iff (reset) count <= CNT_MAX
    );

    // EMPTY state and a zero count always move together
    a_empty_state: assert property (
        @(posedge clk) disable iff (reset) (state == EMPTY) == (count == '0)
    );

endmodule : fifo_ctrl_fsm

// ==== rtl/msg_len_counter.sv ====
module msg_len_counter (
    input  logic                    clk,
    input  logic                    reset,

    // Word stream from the writer
    input  logic                    wr,
    input  logic                    wr_last,

    // Levels of both FIFOs
    input  logic                    word_full,
    input  logic                    len_full,

    // FIFO write strobes and the length payload
    output logic                    word_wr,
    output logic                    len_wr,
    output buf_types_pkg::msg_len_t len_data,

    // Back-pressure and drop report to the writer
    output logic                    full,
    output logic                    oflow
);
    import buf_types_pkg::*;

    // --------------------
    // Signals
    // --------------------

    // Words already accepted in the current message
    msg_len_t count;
    logic     accept;

    // Either FIFO full blocks the word
    // A last word needs a length slot too, so both must have room
    assign full   = word_full || len_full;
    assign accept = wr && !full;

    // Accepted words go straight to the word FIFO
    assign word_wr = accept;

    // Length push in the same cycle as the last word
    // so both become readable together
    assign len_wr   = accept && wr_last;
    assign len_data = msg_len_t'(count + 1'b1);

    // --------------------
    // Message count
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            oflow <= 1'b0;
        end else begin
            if (len_wr) begin
                // Next word starts a new message
                count <= '0;
            end else if (accept) begin
                count <= len_data;
            end
            // Dropped word, flag it for one cycle
            oflow <= wr && full;
        end
    end

    // --------------------
    // Assertions
    // --------------------

    // A message must end by its 255th word
    // otherwise the length field would wrap
    a_len_limit: assert property (
        @(posedge clk) disable iff (reset)
        (accept && !wr_last) |-> (len_data != MSG_LEN_MAX)
    );

endmodule : msg_len_counter

// ==== rtl/fifo_small.sv ====
module fifo_small #(
    parameter type DATA_T = logic [15:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  reset,

    // Write side
    input  logic  wr,
    input  DATA_T wr_data,
    output logic  full,
    output logic  oflow,

    // Read side
    input  logic  rd,
    output DATA_T rd_data,
    output logic  empty,
    output logic  uflow
);
    // --------------------
    // Parameters
    // --------------------

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // --------------------
    // Signals
    // --------------------

    // Small array, maps to distributed memory
    DATA_T              mem [DEPTH];
    logic               wr_safe;
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;

    // --------------------
    // Control FSM
    // --------------------

    fifo_ctrl_fsm #(
        .DEPTH   ( DEPTH )
    ) ctrl (
        .clk     ( clk ),
        .reset   ( reset ),
        .wr      ( wr ),
        .wr_safe ( wr_safe ),
        .wr_ptr  ( wr_ptr ),
        .full    ( full ),
        .oflow   ( oflow ),
        .rd      ( rd ),
        .rd_ptr  ( rd_ptr ),
        .empty   ( empty ),
        .uflow   ( uflow )
    );

    // Store only writes the FSM let through
    always_ff @(posedge clk) begin
        if (wr_safe) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head entry visible without a read strobe
    // Valid once empty drops, one cycle after the write
    assign rd_data = mem[rd_ptr];

endmodule : fifo_small

// ==== rtl/msg_buffer.sv ====
`include "buf_params.svh"

module msg_buffer (
    input  logic                       clk,
    input  logic                       reset,

    // Writer
    input  logic                       wr,
    input  logic [`BUF_WORD_WIDTH-1:0] wr_data,
    input  logic                       wr_last,
    output logic                       full,
    output logic                       oflow,

    // Word reader
    input  logic                       word_rd,
    output logic [`BUF_WORD_WIDTH-1:0] word_data,
    output logic                       word_last,
    output logic                       word_empty,
    output logic                       word_uflow,

    // Length reader
    input  logic                       len_rd,
    output buf_types_pkg::msg_len_t    len_data_out,
    output logic                       len_empty,
    output logic                       len_uflow
);
    import buf_types_pkg::*;

    // --------------------
    // Signals
    // --------------------

    word_t    wr_word;
    word_t    rd_word;
    logic     word_wr;
    logic     word_full;
    logic     len_wr;
    logic     len_full;
    msg_len_t len_data;

    // Word and its last flag travel as one entry
    assign wr_word   = '{data: wr_data, last: wr_last};
    assign word_data = rd_word.data;
    assign word_last = rd_word.last;

    // --------------------
    // Acceptance and length
    // --------------------

    msg_len_counter len_counter (
        .clk       ( clk ),
        .reset     ( reset ),
        .wr        ( wr ),
        .wr_last   ( wr_last ),
        .word_full ( word_full ),
        .len_full  ( len_full ),
        .word_wr   ( word_wr ),
        .len_wr    ( len_wr ),
        .len_data  ( len_data ),
        .full      ( full ),
        .oflow     ( oflow )
    );

    // --------------------
    // FIFOs
    // --------------------

    // Overflow ports stay open, writes are already gated by full
    fifo_small #(
        .DATA_T  ( word_t ),
        .DEPTH   ( `BUF_WORD_DEPTH )
    ) word_fifo (
        .clk     ( clk ),
        .reset   ( reset ),
        .wr      ( word_wr ),
        .wr_data ( wr_word ),
        .full    ( word_full ),
        .oflow   ( ),
        .rd      ( word_rd ),
        .rd_data ( rd_word ),
        .empty   ( word_empty ),
        .uflow   ( word_uflow )
    );

    fifo_small #(
        .DATA_T  ( msg_len_t ),
        .DEPTH   ( `BUF_LEN_DEPTH )
    ) len_fifo (
        .clk     ( clk ),
        .reset   ( reset ),
        .wr      ( len_wr ),
        .wr_data ( len_data ),
        .full    ( len_full ),
        .oflow   ( ),
        .rd      ( len_rd ),
        .rd_data ( len_data_out ),
        .empty   ( len_empty ),
        .uflow   ( len_uflow )
    );

endmodule : msg_buffer

// ==== sim/msg_buffer_checker.sv ====
`include "buf_params.svh"

module msg_buffer_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr,
    input  logic [`BUF_WORD_WIDTH-1:0] wr_data,
    input  logic                       wr_last,
    input  logic                       word_rd,
    input  logic                       len_rd,
    input  logic                       full,
    input  logic                       oflow,
    input  logic [`BUF_WORD_WIDTH-1:0] word_data,
    input  logic                       word_last,
    input  logic                       word_empty,
    input  logic                       word_uflow,
    input  buf_types_pkg::msg_len_t    len_data_out,
    input  logic                       len_empty,
    input  logic                       len_uflow,
    output int                         check_count,
    output int                         error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import buf_types_pkg::*;

    // --------------------
    // Model state
    // --------------------

    word_t    word_q[$];
    msg_len_t len_q[$];
    int       msg_count;
    logic     after_reset;

    // Flag pulses expected in the coming cycle
    logic     exp_oflow;
    logic     exp_word_uflow;
    logic     exp_len_uflow;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // --------------------
    // Compare, then step
    // --------------------

    // Inputs and outputs are sampled before the edge updates them
    always @(posedge clk) begin : model_step
        logic  word_avail;
        logic  len_avail;
        logic  model_full;
        string prefix;
        if (reset) begin
            word_q.delete();
            len_q.delete();
            msg_count      = 0;
            exp_oflow      = 1'b0;
            exp_word_uflow = 1'b0;
            exp_len_uflow  = 1'b0;
            after_reset    = 1'b1;
        end else begin
            prefix     = after_reset ? "after_reset " : "";
            word_avail = (word_q.size() != 0);
            len_avail  = (len_q.size() != 0);
            model_full = (word_q.size() == `BUF_WORD_DEPTH) ||
                         (len_q.size() == `BUF_LEN_DEPTH);

            // Levels against queue sizes
            check_value({prefix, "word_empty"}, !word_avail, word_empty);
            check_value({prefix, "len_empty"}, !len_avail, len_empty);
            check_value({prefix, "full"}, model_full, full);

            // Heads of both FIFOs
            if (word_avail) begin
                check_value("word_data", word_q[0].data, word_data);
                check_value("word_last", word_q[0].last, word_last);
            end
            if (len_avail) begin
                check_value("len_data", len_q[0], len_data_out);
            end

            // One-cycle pulses from the previous cycle
            check_value({prefix, "oflow"}, exp_oflow, oflow);
            check_value({prefix, "word_uflow"}, exp_word_uflow, word_uflow);
            check_value({prefix, "len_uflow"}, exp_len_uflow, len_uflow);

            exp_oflow      = wr && model_full;
            exp_word_uflow = word_rd && !word_avail;
            exp_len_uflow  = len_rd && !len_avail;

            // Reads see the pre-edge contents
            if (word_rd && word_avail) begin
                void'(word_q.pop_front());
            end
            if (len_rd && len_avail) begin
                void'(len_q.pop_front());
            end

            // Dropped words leave the message count alone
            if (wr && !model_full) begin
                word_q.push_back('{data: wr_data, last: wr_last});
                msg_count++;
                if (wr_last) begin
                    len_q.push_back(msg_len_t'(msg_count));
                    msg_count = 0;
                end
            end
            after_reset = 1'b0;
        end
    end

endmodule : msg_buffer_checker

// ==== sim/msg_buffer_tb.sv ====
`include "buf_params.svh"

module msg_buffer_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import buf_types_pkg::*;

    // --------------------
    // Run length
    // --------------------

    localparam int SEED           = 75824;
    localparam int RESET_CYCLES   = 3;
    localparam int STIM_CYCLES    = 2000;
    localparam int PHASE_CYCLES   = 100;
    localparam int MARGIN_CYCLES  = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + MARGIN_CYCLES;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic                       wr = 1'b0;
    logic [`BUF_WORD_WIDTH-1:0] wr_data = '0;
    logic                       wr_last = 1'b0;
    logic                       word_rd = 1'b0;
    logic                       len_rd = 1'b0;
    logic                       full;
    logic                       oflow;
    logic [`BUF_WORD_WIDTH-1:0] word_data;
    logic                       word_last;
    logic                       word_empty;
    logic                       word_uflow;
    msg_len_t                   len_data_out;
    logic                       len_empty;
    logic                       len_uflow;
    int                         check_count;
    int                         error_count;
    int                         cycle_count = 0;

    // Percent chances for the current phase
    int                         wr_pct;
    int                         rd_pct;
    int                         len_pct;

    // 4 ns period
    always #2 clk = ~clk;

    msg_buffer dut0 (
        .clk(clk), .reset(reset),
        .wr(wr), .wr_data(wr_data), .wr_last(wr_last), .full(full), .oflow(oflow),
        .word_rd(word_rd), .word_data(word_data), .word_last(word_last),
        .word_empty(word_empty), .word_uflow(word_uflow),
        .len_rd(len_rd), .len_data_out(len_data_out), .len_empty(len_empty),
        .len_uflow(len_uflow)
    );

    msg_buffer_checker check0 (
        .clk(clk), .reset(reset),
        .wr(wr), .wr_data(wr_data), .wr_last(wr_last), .word_rd(word_rd), .len_rd(len_rd),
        .full(full), .oflow(oflow), .word_data(word_data), .word_last(word_last),
        .word_empty(word_empty), .word_uflow(word_uflow), .len_data_out(len_data_out),
        .len_empty(len_empty), .len_uflow(len_uflow),
        .check_count(check_count), .error_count(error_count)
    );

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic int pick_length();
        return 1 + ($urandom % 16);
    endfunction

    // Heavy writing fills the FIFOs, heavy reading drains and underflows them
    task automatic select_phase();
        case ($urandom % 3)
            0: begin
                wr_pct  = 85;
                rd_pct  = 15;
                len_pct = 10;
            end
            1: begin
                wr_pct  = 15;
                rd_pct  = 85;
                len_pct = 80;
            end
            default: begin
                wr_pct  = 50;
                rd_pct  = 50;
                len_pct = 40;
            end
        endcase
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin : stimulus
        int seed_ret;
        int msg_left;
        seed_ret = $urandom(SEED);
        msg_left = pick_length();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clk);
            if (cyc % PHASE_CYCLES == 0) begin
                select_phase();
            end
            // Position in the message moves only on an accepted word
            if (wr && !full) begin
                msg_left = wr_last ? pick_length() : msg_left - 1;
            end
            wr      <= chance(wr_pct);
            wr_data <= `BUF_WORD_WIDTH'($urandom);
            wr_last <= (msg_left == 1);
            word_rd <= chance(rd_pct);
            len_rd  <= chance(len_pct);
        end
        @(posedge clk);
        wr      <= 1'b0;
        word_rd <= 1'b0;
        len_rd  <= 1'b0;
        // Let the last pulses reach the checker
        repeat (3) @(posedge clk);
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // --------------------
    // Timeout
    // --------------------

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : msg_buffer_tb

// ==== list.f ====
+incdir+rtl
rtl/buf_types_pkg.sv
rtl/fifo_pkg.sv
rtl/fifo_ctrl_fsm.sv
rtl/msg_len_counter.sv
rtl/fifo_small.sv
rtl/msg_buffer.sv
sim/msg_buffer_checker.sv
sim/msg_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: msg_buffer

export_include_dirs:
  - rtl

sources:
  - rtl/buf_types_pkg.sv
  - rtl/fifo_pkg.sv
  - rtl/fifo_ctrl_fsm.sv
  - rtl/msg_len_counter.sv
  - rtl/fifo_small.sv
  - rtl/msg_buffer.sv
  - target: test
    files:
      - sim/msg_buffer_checker.sv
      - sim/msg_buffer_tb.sv
